//--- common/qubit_pkg.sv
package qubit_pkg;

    // one detection word covers 32 positions, two pulse slots each
    localparam int QUBIT_WIDTH = 32;
    localparam int PULSE_WIDTH = 64;
    localparam int KEY_WIDTH   = 64;
    localparam int ADDR_WIDTH  = 15;

    typedef logic [PULSE_WIDTH-1:0] detect_word_t;
    typedef logic [QUBIT_WIDTH-1:0] qubit_mask_t;
    typedef logic [KEY_WIDTH-1:0]   key_word_t;

    // detection memory read port
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } detect_rd_t;

    // sifted-key memory write port
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        key_word_t             data;
        logic                  en;
    } key_wr_t;

    // transmit FIFO write side
    typedef struct packed {
        logic [31:0] data;
        logic        en;
    } tx_wr_t;

    // receive FIFO read data, valid one cycle after rd_en
    typedef struct packed {
        qubit_mask_t data;
        logic        valid;
    } decoy_rd_t;

endpackage

//--- common/b2a_pkg.sv
package b2a_pkg;

    // Bob to Alice message types
    localparam logic [7:0] MSG_Z_DETECTED = 8'h02;

    // first word of every packet
    typedef struct packed {
        logic [7:0] msg_type;
        logic [7:0] pkt_len;
        logic [7:0] rsvd;
        logic [7:0] round_num;
    } b2a_header_t;

    // a transmit word is either a header or a raw payload word
    typedef union packed {
        b2a_header_t hdr;
        logic [31:0] raw;
    } b2a_word_u;

endpackage

//--- logic/sift_sequencer.sv
`timescale 1ns/1ps

module sift_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start_sift,
    input  logic start_tx,
    input  logic report_done,
    input  logic delete_done,
    output logic wait_tx,
    output logic report_en,
    output logic delete_en,
    output logic clear,
    output logic sift_finish
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_REPORT,
        ST_REPORT_END,
        ST_DELETE,
        ST_DELETE_END,
        ST_CLEAR,
        ST_FINISH
    } phase_t;

    phase_t state;
    phase_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:       if (start_sift) state_next = ST_START;
            // hold here until Alice side is ready to take packets
            ST_START:      if (start_tx) state_next = ST_REPORT;
            ST_REPORT:     if (report_done) state_next = ST_REPORT_END;
            ST_REPORT_END: state_next = ST_DELETE;
            ST_DELETE:     if (delete_done) state_next = ST_DELETE_END;
            ST_DELETE_END: state_next = ST_CLEAR;
            ST_CLEAR:      state_next = ST_FINISH;
            ST_FINISH:     state_next = ST_IDLE;
            default:       state_next = ST_IDLE;
        endcase
    end

    // phase outputs decoded straight from the state register
    assign wait_tx     = (state == ST_START);
    assign report_en   = (state == ST_REPORT);
    assign delete_en   = (state == ST_DELETE);
    assign clear       = (state == ST_CLEAR);
    assign sift_finish = (state == ST_FINISH);

endmodule

//--- logic/zbasis_reporter.sv
`timescale 1ns/1ps

module zbasis_reporter #(
    parameter int Z_ROUNDS        = 32,
    parameter int WORDS_PER_ROUND = 1024
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   report_en,
    input  logic                   tx_empty,
    input  qubit_pkg::qubit_mask_t detect_mask,
    output qubit_pkg::detect_rd_t  detect_rd,
    output qubit_pkg::tx_wr_t      tx_wr,
    output logic                   report_done
);
    import qubit_pkg::*;
    import b2a_pkg::*;

    localparam int ROUND_W = (Z_ROUNDS > 1) ? $clog2(Z_ROUNDS) : 1;
    localparam int WORD_W  = (WORDS_PER_ROUND > 1) ? $clog2(WORDS_PER_ROUND) : 1;
    // header plus payload, in bytes
    localparam logic [7:0] PKT_LEN = 8'((WORDS_PER_ROUND + 1) * 4);

    typedef enum logic [2:0] {
        R_IDLE,
        R_WAIT,
        R_RUN,
        R_NEXT,
        R_DONE
    } round_state_t;

    round_state_t       state;
    round_state_t       state_next;
    logic [ROUND_W-1:0] round_cnt;
    logic [WORD_W-1:0]  word_cnt;
    logic               last_word;
    logic               last_round;
    logic               hdr_wr;
    logic               issue_d1;
    logic               issue_d2;
    b2a_word_u          tx_word;
    logic               tx_en;

    assign last_word  = (word_cnt == WORD_W'(WORDS_PER_ROUND - 1));
    assign last_round = (round_cnt == ROUND_W'(Z_ROUNDS - 1));
    assign hdr_wr     = (state == R_RUN) && (word_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= R_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            R_IDLE:  if (report_en) state_next = R_WAIT;
            // a round only starts once the FIFO has drained
            R_WAIT:  if (tx_empty) state_next = R_RUN;
            R_RUN:   if (last_word) state_next = R_NEXT;
            R_NEXT:  state_next = last_round ? R_DONE : R_WAIT;
            R_DONE:  state_next = R_IDLE;
            default: state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            round_cnt <= '0;
            word_cnt  <= '0;
        end else begin
            if (state == R_RUN) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            if (state == R_NEXT) begin
                round_cnt <= last_round ? '0 : round_cnt + 1'b1;
            end
        end
    end

    assign detect_rd.addr = ADDR_WIDTH'(int'(round_cnt) * WORDS_PER_ROUND + int'(word_cnt));

    // memory latency plus the fetch register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_d1 <= 1'b0;
            issue_d2 <= 1'b0;
            tx_en    <= 1'b0;
        end else begin
            issue_d1 <= (state == R_RUN);
            issue_d2 <= issue_d1;
            tx_en    <= hdr_wr | issue_d2;
        end
    end

    // header goes out while the first payload word is still in the memory pipe
    always_ff @(posedge clk) begin
        if (hdr_wr) begin
            tx_word.hdr <= '{
                msg_type:  MSG_Z_DETECTED,
                pkt_len:   PKT_LEN,
                rsvd:      8'h00,
                round_num: 8'(round_cnt)
            };
        end else begin
            tx_word.raw <= detect_mask;
        end
    end

    assign tx_wr.data  = tx_word.raw;
    assign tx_wr.en    = tx_en;
    assign report_done = (state == R_DONE);

endmodule

//--- deletion/detect_fetch.sv
`timescale 1ns/1ps

module detect_fetch #(
    parameter int DETECT_WORDS = 32768
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    delete_en,
    input  logic                    clear,
    input  qubit_pkg::detect_rd_t   report_rd,
    input  qubit_pkg::detect_word_t detect_dout,
    input  logic                    decoy_empty,
    input  qubit_pkg::decoy_rd_t    decoy_rd,
    output qubit_pkg::detect_rd_t   detect_rd,
    output logic                    decoy_rd_en,
    output qubit_pkg::detect_word_t detect_word,
    output qubit_pkg::qubit_mask_t  detect_mask,
    output logic                    keep_valid,
    output qubit_pkg::qubit_mask_t  notdecoy_mask,
    output logic                    delete_done
);
    import qubit_pkg::*;

    localparam int CNT_W = $clog2(DETECT_WORDS + 1);

    logic [CNT_W-1:0]      rd_cnt;
    logic [CNT_W-1:0]      align_cnt;
    logic [ADDR_WIDTH-1:0] del_addr;
    logic                  valid_d1;
    qubit_mask_t           decoy_d1;

    assign decoy_rd_en = delete_en && !decoy_empty && (rd_cnt < CNT_W'(DETECT_WORDS));

    // decoy word k reads detection word k in its valid cycle
    assign detect_rd.addr = delete_en ? del_addr : report_rd.addr;

    always_ff @(posedge clk) begin
        detect_word <= detect_dout;
    end

    // a position counts as detected when either slot fired
    always_comb begin
        for (int i = 0; i < QUBIT_WIDTH; i++) begin
            detect_mask[i] = detect_word[2*i+1] | detect_word[2*i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            rd_cnt    <= '0;
            del_addr  <= '0;
            align_cnt <= '0;
        end else begin
            if (decoy_rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (decoy_rd.valid) begin
                del_addr <= del_addr + 1'b1;
            end
            if (keep_valid) begin
                align_cnt <= align_cnt + 1'b1;
            end
        end
    end

    // mask waits two cycles to line up with the registered detection word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d1    <= 1'b0;
            keep_valid  <= 1'b0;
            delete_done <= 1'b0;
        end else begin
            valid_d1    <= decoy_rd.valid;
            keep_valid  <= valid_d1;
            delete_done <= keep_valid && (align_cnt == CNT_W'(DETECT_WORDS - 1));
        end
    end

    always_ff @(posedge clk) begin
        decoy_d1      <= decoy_rd.data;
        notdecoy_mask <= decoy_d1;
    end

endmodule

//--- deletion/qubit_deletion.sv
`timescale 1ns/1ps

module qubit_deletion (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    keep_valid,
    input  qubit_pkg::detect_word_t detect_word,
    input  qubit_pkg::qubit_mask_t  detect_mask,
    input  qubit_pkg::qubit_mask_t  notdecoy_mask,
    output qubit_pkg::key_wr_t      key_wr
);
    import qubit_pkg::*;

    localparam int RING_W = 2 * KEY_WIDTH;
    localparam int OFF_W  = $clog2(RING_W);
    localparam int RANK_W = $clog2(QUBIT_WIDTH);

    qubit_mask_t           keep;
    logic [RANK_W:0]       keep_cnt;
    logic [RANK_W-1:0]     rank [QUBIT_WIDTH];
    logic [OFF_W-1:0]      bit_pos [QUBIT_WIDTH];
    qubit_mask_t           pair_bit;
    logic [OFF_W:0]        next_fill;
    logic [OFF_W-1:0]      offset;
    logic [RING_W-1:0]     ring;
    logic                  full_hi;
    logic                  full_lo;
    logic [ADDR_WIDTH-1:0] key_addr;
    logic [ADDR_WIDTH-1:0] key_addr_q;
    key_word_t             key_data;
    logic                  key_en;

    assign keep = keep_valid ? (notdecoy_mask & detect_mask) : '0;

    // rank is the number of kept positions above i, so position 31 goes first
    always_comb begin
        keep_cnt = '0;
        for (int i = QUBIT_WIDTH - 1; i >= 0; i--) begin
            rank[i]  = keep_cnt[RANK_W-1:0];
            keep_cnt = keep_cnt + (RANK_W+1)'(keep[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < QUBIT_WIDTH; i++) begin
            bit_pos[i] = OFF_W'(RING_W - 1) - OFF_W'(rank[i]) - offset;
            case (detect_word[2*i +: 2])
                2'b10:   pair_bit[i] = 1'b0;
                2'b01:   pair_bit[i] = 1'b1;
                // double click, fall back on the index parity
                default: pair_bit[i] = i[0];
            endcase
        end
    end

    assign next_fill = {1'b0, offset} + (OFF_W+1)'(keep_cnt);

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUBIT_WIDTH; i++) begin
            if (keep[i]) begin
                ring[bit_pos[i]] <= pair_bit[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            offset  <= '0;
            full_hi <= 1'b0;
            full_lo <= 1'b0;
        end else begin
            offset  <= offset + OFF_W'(keep_cnt);
            full_hi <= (offset < OFF_W'(KEY_WIDTH)) && (next_fill >= (OFF_W+1)'(KEY_WIDTH));
            full_lo <= (next_fill >= (OFF_W+1)'(RING_W));
        end
    end

    // one half of the ring is written out per fill
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            key_en   <= 1'b0;
            key_addr <= '0;
        end else begin
            key_en <= full_hi | full_lo;
            if (full_hi | full_lo) begin
                key_addr <= key_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        key_addr_q <= key_addr;
        key_data   <= full_hi ? ring[RING_W-1:KEY_WIDTH] : ring[KEY_WIDTH-1:0];
    end

    assign key_wr.addr = key_addr_q;
    assign key_wr.data = key_data;
    assign key_wr.en   = key_en;

endmodule

//--- logic/bob_sift_top.sv
`timescale 1ns/1ps

module bob_sift_top #(
    parameter int Z_ROUNDS        = 32,
    parameter int WORDS_PER_ROUND = 1024,
    parameter int DETECT_WORDS    = 32768
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_sift,
    input  logic                     start_tx,
    output logic                     wait_tx,
    output logic                     sift_finish,
    output qubit_pkg::detect_rd_t    detect_rd,
    input  qubit_pkg::detect_word_t  detect_dout,
    input  logic                     tx_empty,
    output qubit_pkg::tx_wr_t        tx_wr,
    input  logic                     decoy_empty,
    output logic                     decoy_rd_en,
    input  qubit_pkg::decoy_rd_t     decoy_rd,
    output qubit_pkg::key_wr_t       key_wr
);
    import qubit_pkg::*;

    logic         report_en;
    logic         delete_en;
    logic         clear;
    logic         report_done;
    logic         delete_done;
    detect_rd_t   report_rd;
    detect_word_t detect_word;
    qubit_mask_t  detect_mask;
    logic         keep_valid;
    qubit_mask_t  notdecoy_mask;

    sift_sequencer sift_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_sift  (start_sift),
        .start_tx    (start_tx),
        .report_done (report_done),
        .delete_done (delete_done),
        .wait_tx     (wait_tx),
        .report_en   (report_en),
        .delete_en   (delete_en),
        .clear       (clear),
        .sift_finish (sift_finish)
    );

    zbasis_reporter #(
        .Z_ROUNDS        (Z_ROUNDS),
        .WORDS_PER_ROUND (WORDS_PER_ROUND)
    ) zbasis_reporter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .report_en   (report_en),
        .tx_empty    (tx_empty),
        .detect_mask (detect_mask),
        .detect_rd   (report_rd),
        .tx_wr       (tx_wr),
        .report_done (report_done)
    );

    detect_fetch #(
        .DETECT_WORDS (DETECT_WORDS)
    ) detect_fetch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .delete_en     (delete_en),
        .clear         (clear),
        .report_rd     (report_rd),
        .detect_dout   (detect_dout),
        .decoy_empty   (decoy_empty),
        .decoy_rd      (decoy_rd),
        .detect_rd     (detect_rd),
        .decoy_rd_en   (decoy_rd_en),
        .detect_word   (detect_word),
        .detect_mask   (detect_mask),
        .keep_valid    (keep_valid),
        .notdecoy_mask (notdecoy_mask),
        .delete_done   (delete_done)
    );

    qubit_deletion qubit_deletion_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .keep_valid    (keep_valid),
        .detect_word   (detect_word),
        .detect_mask   (detect_mask),
        .notdecoy_mask (notdecoy_mask),
        .key_wr        (key_wr)
    );

endmodule

//--- test/sift_model.svh
`ifndef SIFT_MODEL_SVH
`define SIFT_MODEL_SVH

// a position is detected when either of its two pulse slots fired
function automatic qubit_mask_t pair_or(input detect_word_t w);
    qubit_mask_t m;
    for (int i = 0; i < QUBIT_WIDTH; i++) begin
        m[i] = (w[2*i +: 2] != 2'b00);
    end
    return m;
endfunction

// type, length in bytes, reserved zero, round number
function automatic logic [31:0] header_word(input int round);
    logic [7:0] pkt_len;
    pkt_len = 8'(4 * (1 + WORDS_PER_ROUND));
    return {MSG_Z_DETECTED, pkt_len, 8'h00, 8'(round)};
endfunction

// serial key stream, first kept bit lands in the word MSB
task automatic build_key_model();
    qubit_mask_t keep;
    key_word_t   acc;
    int          nbits;
    logic        hi;
    logic        lo;
    logic        key_bit;
    exp_key_cnt = 0;
    nbits       = 0;
    acc         = '0;
    for (int k = 0; k < DETECT_WORDS; k++) begin
        keep = decoy_mem[k] & pair_or(det_mem[k]);
        // position 31 is taken first
        for (int i = QUBIT_WIDTH - 1; i >= 0; i--) begin
            if (keep[i]) begin
                hi = det_mem[k][2*i+1];
                lo = det_mem[k][2*i];
                if (hi && !lo) begin
                    key_bit = 1'b0;
                end else if (!hi && lo) begin
                    key_bit = 1'b1;
                end else begin
                    key_bit = (i % 2 == 1);
                end
                acc = {acc[KEY_WIDTH-2:0], key_bit};
                nbits++;
                if (nbits == KEY_WIDTH) begin
                    exp_key[exp_key_cnt] = acc;
                    exp_key_cnt++;
                    nbits = 0;
                end
            end
        end
    end
endtask

`endif

//--- test/bob_sift_tb.sv
`timescale 1ns/1ps

module bob_sift_tb;
    import qubit_pkg::*;
    import b2a_pkg::*;

    localparam int Z_ROUNDS        = 4;
    localparam int WORDS_PER_ROUND = 8;
    localparam int DETECT_WORDS    = 32;
    localparam int TX_WORDS        = Z_ROUNDS * (WORDS_PER_ROUND + 1);
    localparam int KEY_MAX         = DETECT_WORDS * QUBIT_WIDTH / KEY_WIDTH;
    localparam int CLK_HALF        = 5;
    localparam int RUN_TIMEOUT     = 4000;

    logic         clk;
    logic         rst_n;
    logic         start_sift;
    logic         start_tx;
    logic         wait_tx;
    logic         sift_finish;
    detect_rd_t   detect_rd;
    detect_word_t detect_dout;
    logic         tx_empty;
    tx_wr_t       tx_wr;
    logic         decoy_empty;
    logic         decoy_rd_en;
    decoy_rd_t    decoy_rd;
    key_wr_t      key_wr;

    // memory and FIFO contents of the current run
    detect_word_t det_mem [DETECT_WORDS];
    qubit_mask_t  decoy_mem [DETECT_WORDS];
    key_word_t    exp_key [KEY_MAX];
    int           exp_key_cnt;

    logic [15:0]  lfsr_state;
    int           addr_q;
    logic         rd_en_q;
    logic         empty_d1;
    logic         empty_d2;
    int           tx_cnt;
    int           key_cnt;
    int           read_cnt;
    int           finish_cnt;

    `include "sift_model.svh"

    bob_sift_top #(
        .Z_ROUNDS        (Z_ROUNDS),
        .WORDS_PER_ROUND (WORDS_PER_ROUND),
        .DETECT_WORDS    (DETECT_WORDS)
    ) bob_sift_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_sift  (start_sift),
        .start_tx    (start_tx),
        .wait_tx     (wait_tx),
        .sift_finish (sift_finish),
        .detect_rd   (detect_rd),
        .detect_dout (detect_dout),
        .tx_empty    (tx_empty),
        .tx_wr       (tx_wr),
        .decoy_empty (decoy_empty),
        .decoy_rd_en (decoy_rd_en),
        .decoy_rd    (decoy_rd),
        .key_wr      (key_wr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        out;
        r = '0;
        for (int i = 0; i < n; i++) begin
            out        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            r = {r[62:0], out};
        end
        return r;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_outputs();
        int          round;
        int          word;
        logic [31:0] exp_word;
        if (tx_wr.en === 1'b1) begin
            round = tx_cnt / (WORDS_PER_ROUND + 1);
            word  = tx_cnt % (WORDS_PER_ROUND + 1);
            if (word == 0) begin
                exp_word = header_word(round);
            end else begin
                exp_word = pair_or(det_mem[round * WORDS_PER_ROUND + word - 1]);
            end
            if (tx_cnt >= TX_WORDS) begin
                abort_run("more transmit words than the report holds");
            end else if (word == 0 && empty_d2 !== 1'b1) begin
                abort_run("report round started while tx_empty was low");
            end else begin
                check_value("tx_wr.data", 64'(tx_wr.data), 64'(exp_word));
                tx_cnt++;
            end
        end
        if (key_wr.en === 1'b1) begin
            if (finish_cnt != 0) begin
                abort_run("key write after sift_finish");
            end else if (key_cnt >= exp_key_cnt) begin
                abort_run("more key words written than the model holds");
            end else begin
                check_value("key_wr.addr", 64'(key_wr.addr), 64'(key_cnt));
                check_value("key_wr.data", key_wr.data, exp_key[key_cnt]);
                key_cnt++;
            end
        end
        if (sift_finish === 1'b1) begin
            finish_cnt++;
        end
    endtask

    // one clock: sample requests before the rising edge, answer on the falling edge
    task automatic step_cycle();
        #(CLK_HALF - 1);
        addr_q  = int'(detect_rd.addr);
        rd_en_q = (decoy_rd_en === 1'b1);
        @(negedge clk);
        check_outputs();
        detect_dout    = (addr_q < DETECT_WORDS) ? det_mem[addr_q] : '0;
        decoy_rd.valid = rd_en_q;
        decoy_rd.data  = '0;
        if (rd_en_q) begin
            if (read_cnt >= DETECT_WORDS) begin
                abort_run("decoy read issued after the last decoy word");
            end else begin
                decoy_rd.data = decoy_mem[read_cnt];
                read_cnt++;
            end
        end
        empty_d2    = empty_d1;
        tx_empty    = |rand_bits(2);
        empty_d1    = tx_empty;
        decoy_empty = (rand_bits(3) == 64'd0);
    endtask

    task automatic run_sift();
        int wait_cnt;
        int hold;
        for (int a = 0; a < DETECT_WORDS; a++) begin
            det_mem[a]   = rand_bits(64);
            decoy_mem[a] = 32'(rand_bits(32));
        end
        build_key_model();
        tx_cnt     = 0;
        key_cnt    = 0;
        read_cnt   = 0;
        finish_cnt = 0;
        start_sift = 1'b1;
        step_cycle();
        start_sift = 1'b0;
        // wait_tx follows start_sift by one cycle
        check_value("wait_tx", 64'(wait_tx), 64'd1);
        // wait_tx has to hold while Alice is not ready
        hold = 2 + int'(rand_bits(3));
        for (int c = 0; c < hold; c++) begin
            step_cycle();
            check_value("wait_tx", 64'(wait_tx), 64'd1);
        end
        start_tx = 1'b1;
        step_cycle();
        check_value("wait_tx", 64'(wait_tx), 64'd0);
        wait_cnt = 0;
        while (sift_finish !== 1'b1) begin
            if (wait_cnt >= RUN_TIMEOUT) begin
                abort_run("timed out waiting for sift_finish");
            end else begin
                step_cycle();
                wait_cnt++;
            end
        end
        start_tx = 1'b0;
        // nothing may follow the finish pulse
        repeat (6) step_cycle();
        check_value("sift_finish pulses", 64'(finish_cnt), 64'd1);
        check_value("transmit words", 64'(tx_cnt), 64'(TX_WORDS));
        check_value("decoy reads", 64'(read_cnt), 64'(DETECT_WORDS));
        check_value("key words", 64'(key_cnt), 64'(exp_key_cnt));
    endtask

    initial begin
        lfsr_state  = 16'd55069;
        rst_n       = 1'b0;
        start_sift  = 1'b0;
        start_tx    = 1'b0;
        tx_empty    = 1'b1;
        decoy_empty = 1'b1;
        detect_dout = '0;
        decoy_rd    = '0;
        addr_q      = 0;
        rd_en_q     = 1'b0;
        empty_d1    = 1'b1;
        empty_d2    = 1'b1;
        tx_cnt      = 0;
        key_cnt     = 0;
        read_cnt    = 0;
        finish_cnt  = 0;
        exp_key_cnt = 0;
        repeat (2) step_cycle();
        rst_n = 1'b1;
        step_cycle();
        check_value("tx_wr.en", 64'(tx_wr.en), 64'd0);
        check_value("key_wr.en", 64'(key_wr.en), 64'd0);
        check_value("decoy_rd_en", 64'(decoy_rd_en), 64'd0);
        check_value("wait_tx", 64'(wait_tx), 64'd0);
        check_value("sift_finish", 64'(sift_finish), 64'd0);
        // second run with fresh data, key addresses start over
        run_sift();
        run_sift();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+test
common/qubit_pkg.sv
common/b2a_pkg.sv
logic/sift_sequencer.sv
logic/zbasis_reporter.sv
deletion/detect_fetch.sv
deletion/qubit_deletion.sv
logic/bob_sift_top.sv
test/bob_sift_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := bob_sift_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
